/* hdl/read_command_queue.sv */
//////////////////////////////////////////////////
// grant and request are registered once
// a grant seen while alfull is high is dropped
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vertex_job_settings.svh"

module read_command_queue
	import vertex_job_pkg::*;
(
	input  logic          clock,
	input  logic          rstn,
	input  logic          command_push,
	input  read_command_t command,
	output logic          empty,
	input  logic          read_buffer_alfull,
	input  logic          read_command_grant,
	output logic          read_command_request,
	output logic          read_command_valid,
	output read_command_t read_command
);

	logic grant_q;
	logic command_pop;

	assign command_pop = grant_q && !read_buffer_alfull;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			grant_q              <= 1'b0;
			read_command_request <= 1'b0;
		end else begin
			grant_q              <= read_command_grant;
			read_command_request <= !empty && !read_buffer_alfull;
		end
	end

	sync_fifo #(
		.WIDTH            ($bits(read_command_t)),
		.DEPTH            (`VJ_CMD_FIFO_DEPTH),
		.ALMOST_FULL_LEVEL(`VJ_CMD_FIFO_DEPTH - 1)
	) u_command_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (command_push),
		.data_in    (command),
		.full       (),
		.almost_full(),
		.pop        (command_pop),
		.valid      (read_command_valid),
		.data_out   (read_command),
		.empty      (empty)
	);

endmodule

`default_nettype wire

/* hdl/sync_fifo.sv */
//////////////////////////////////////////////////
// DEPTH must be a power of two
// push when full and pop when empty are dropped
// valid pulses one cycle after an accepted pop
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH             = 32,
	parameter int DEPTH             = 16,
	parameter int ALMOST_FULL_LEVEL = DEPTH - 1
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	output logic             full,
	output logic             almost_full,
	input  logic             pop,
	output logic             valid,
	output logic [WIDTH-1:0] data_out,
	output logic             empty
);

	localparam int PTR_BITS   = $clog2(DEPTH);
	localparam int COUNT_BITS = PTR_BITS + 1;

	logic [WIDTH-1:0]      mem [DEPTH];
	logic [PTR_BITS-1:0]   wr_ptr;
	logic [PTR_BITS-1:0]   rd_ptr;
	logic [COUNT_BITS-1:0] count;
	logic                  do_push;
	logic                  do_pop;

	assign full        = (count == COUNT_BITS'(DEPTH));
	assign almost_full = (count >= COUNT_BITS'(ALMOST_FULL_LEVEL));
	assign empty       = (count == '0);
	assign do_push     = push && !full;
	assign do_pop      = pop && !empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			valid  <= 1'b0;
		end else begin
			valid <= do_pop;
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage and registered read port
	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
		if (do_pop)
			data_out <= mem[rd_ptr];
	end

endmodule

`default_nettype wire

/* hdl/vertex_job_control.sv */
//////////////////////////////////////////////////
// vertex job controller of one compute unit
// wed must stay stable while wed_valid is high
// a vertex_request to an empty buffer is ignored
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vertex_job_settings.svh"

module vertex_job_control
	import vertex_job_pkg::*;
(
	input  logic           clock,
	input  logic           rstn,
	input  logic           wed_valid,
	input  wed_t           wed,
	input  logic           read_command_grant,
	input  logic           read_buffer_alfull,
	output logic           read_command_request,
	output logic           read_command_valid,
	output read_command_t  read_command,
	input  logic           read_response_valid,
	input  read_response_t read_response,
	input  logic           read_data_0_valid,
	input  logic           read_data_1_valid,
	input  read_data_t     read_data_0,
	input  read_data_t     read_data_1,
	input  logic           vertex_request,
	output logic           vertex_valid,
	output vertex_t        vertex
);

	logic          command_push;
	read_command_t command;
	logic          command_queue_empty;
	logic          vertex_almost_full;
	logic          line_ready;
	line_count_t   half_0_count;
	line_count_t   half_1_count;
	logic          clear_line;
	logic          shift_half_0;
	logic          shift_half_1;
	logic          vertex_push;
	vertex_t       vertex_out;

	vertex_read_sequencer u_vertex_read_sequencer (
		.clock              (clock),
		.rstn               (rstn),
		.wed_valid          (wed_valid),
		.wed                (wed),
		.command_queue_empty(command_queue_empty),
		.vertex_room        (!vertex_almost_full),
		.line_ready         (line_ready),
		.half_0_count       (half_0_count),
		.half_1_count       (half_1_count),
		.command_push       (command_push),
		.command            (command),
		.clear_line         (clear_line),
		.shift_half_0       (shift_half_0),
		.shift_half_1       (shift_half_1)
	);

	vertex_line_unpacker u_vertex_line_unpacker (
		.clock              (clock),
		.rstn               (rstn),
		.wed                (wed),
		.read_response_valid(read_response_valid),
		.read_response      (read_response),
		.read_data_0_valid  (read_data_0_valid),
		.read_data_1_valid  (read_data_1_valid),
		.read_data_0        (read_data_0),
		.read_data_1        (read_data_1),
		.clear_line         (clear_line),
		.shift_half_0       (shift_half_0),
		.shift_half_1       (shift_half_1),
		.line_ready         (line_ready),
		.half_0_count       (half_0_count),
		.half_1_count       (half_1_count),
		.vertex_push        (vertex_push),
		.vertex_out         (vertex_out)
	);

	read_command_queue u_read_command_queue (
		.clock               (clock),
		.rstn                (rstn),
		.command_push        (command_push),
		.command             (command),
		.empty               (command_queue_empty),
		.read_buffer_alfull  (read_buffer_alfull),
		.read_command_grant  (read_command_grant),
		.read_command_request(read_command_request),
		.read_command_valid  (read_command_valid),
		.read_command        (read_command)
	);

	// almost full leaves exactly one line of room
	sync_fifo #(
		.WIDTH            ($bits(vertex_t)),
		.DEPTH            (`VJ_VERTEX_FIFO_DEPTH),
		.ALMOST_FULL_LEVEL(`VJ_VERTEX_FIFO_DEPTH - `VJ_LINE_VERTICES)
	) u_vertex_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (vertex_push),
		.data_in    (vertex_out),
		.full       (),
		.almost_full(vertex_almost_full),
		.pop        (vertex_request),
		.valid      (vertex_valid),
		.data_out   (vertex),
		.empty      ()
	);

endmodule

`default_nettype wire

/* hdl/vertex_job_pkg.sv */
//////////////////////////////////////////////////
// shared types of the vertex job controller
// real_size counts vertices, not bytes
//////////////////////////////////////////////////

`default_nettype none

`include "vertex_job_settings.svh"

package vertex_job_pkg;

	typedef logic [`VJ_VERTEX_BITS-1:0] vertex_word_t;
	typedef logic [`VJ_ADDR_BITS-1:0] byte_addr_t;
	typedef logic [$clog2(`VJ_LINE_VERTICES + 1)-1:0] line_count_t;
	typedef logic [`VJ_HALF_VERTICES*`VJ_VERTEX_BITS-1:0] half_line_t;

	typedef enum logic {
		OUT_DEGREE,
		EDGES_IDX
	} array_sel_t;

	typedef enum logic [3:0] {
		SEQ_WAIT_WED,
		SEQ_LOAD,
		SEQ_IDLE,
		SEQ_START,
		SEQ_SIZE,
		SEQ_OUT_DEGREE,
		SEQ_EDGES_IDX,
		SEQ_WAIT_LINE,
		SEQ_SHIFT_0,
		SEQ_SHIFT_1,
		SEQ_CLEAR
	} seq_state_t;

	// work descriptor from the host
	typedef struct packed {
		vertex_word_t num_vertices;
		vertex_word_t first_id;
		byte_addr_t   out_degree_base;
		byte_addr_t   edges_idx_base;
	} wed_t;

	typedef struct packed {
		byte_addr_t  address;
		array_sel_t  array_sel;
		line_count_t real_size;
	} read_command_t;

	typedef struct packed {
		array_sel_t  array_sel;
		line_count_t real_size;
	} read_response_t;

	typedef struct packed {
		array_sel_t array_sel;
		half_line_t data;
	} read_data_t;

	typedef struct packed {
		vertex_word_t id;
		vertex_word_t out_degree;
		vertex_word_t edges_idx;
	} vertex_t;

endpackage

`default_nettype wire

/* hdl/vertex_job_settings.svh */
//////////////////////////////////////////////////
// widths and cacheline geometry of the vertex job controller
// FIFO depths must be powers of two
// the vertex buffer needs room for at least two lines
//////////////////////////////////////////////////

`ifndef VERTEX_JOB_SETTINGS_SVH
`define VERTEX_JOB_SETTINGS_SVH

// field widths
`define VJ_VERTEX_BITS 32
`define VJ_ADDR_BITS 32

// one cacheline holds 16 vertices, delivered as two halves
`define VJ_LINE_VERTICES 16
`define VJ_HALF_VERTICES 8
`define VJ_LINE_BYTES 64

// buffer depths
`define VJ_CMD_FIFO_DEPTH 16
`define VJ_VERTEX_FIFO_DEPTH 32

`endif

/* hdl/vertex_line_unpacker.sv */
//////////////////////////////////////////////////
// vertex 0 of each half sits in the most significant word
// counts come from the first response of a line
// a vertex is pushed two cycles after its shift strobe
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vertex_job_settings.svh"

module vertex_line_unpacker
	import vertex_job_pkg::*;
(
	input  logic           clock,
	input  logic           rstn,
	input  wed_t           wed,
	input  logic           read_response_valid,
	input  read_response_t read_response,
	input  logic           read_data_0_valid,
	input  logic           read_data_1_valid,
	input  read_data_t     read_data_0,
	input  read_data_t     read_data_1,
	input  logic           clear_line,
	input  logic           shift_half_0,
	input  logic           shift_half_1,
	output logic           line_ready,
	output line_count_t    half_0_count,
	output line_count_t    half_1_count,
	output logic           vertex_push,
	output vertex_t        vertex_out
);

	localparam int HALF_BITS = $bits(half_line_t);

	half_line_t   out_degree_half [2];
	half_line_t   edges_idx_half [2];
	read_data_t   half_data [2];
	logic         half_valid [2];
	logic         half_shift [2];
	logic         out_degree_ready;
	logic         edges_idx_ready;
	logic         shift_sel;
	logic         shift_d;
	vertex_word_t out_degree_word;
	vertex_word_t edges_idx_word;
	vertex_word_t id_count;

	assign half_data[0]  = read_data_0;
	assign half_data[1]  = read_data_1;
	assign half_valid[0] = read_data_0_valid;
	assign half_valid[1] = read_data_1_valid;
	assign half_shift[0] = shift_half_0;
	assign half_shift[1] = shift_half_1;
	assign shift_sel     = shift_half_1;
	assign line_ready    = out_degree_ready && edges_idx_ready;

	//////////////////////////////////////////////////
	// half-line capture and shift
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		for (int h = 0; h < 2; h++) begin
			if (half_valid[h]) begin
				if (half_data[h].array_sel == OUT_DEGREE)
					out_degree_half[h] <= half_data[h].data;
				else
					edges_idx_half[h] <= half_data[h].data;
			end else if (half_shift[h]) begin
				out_degree_half[h] <= out_degree_half[h] << `VJ_VERTEX_BITS;
				edges_idx_half[h]  <= edges_idx_half[h] << `VJ_VERTEX_BITS;
			end
		end
	end

	// ready flags and per-half counts
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			out_degree_ready <= 1'b0;
			edges_idx_ready  <= 1'b0;
			half_0_count     <= '0;
			half_1_count     <= '0;
		end else if (clear_line) begin
			out_degree_ready <= 1'b0;
			edges_idx_ready  <= 1'b0;
			half_0_count     <= '0;
			half_1_count     <= '0;
		end else if (read_response_valid) begin
			if (read_response.array_sel == OUT_DEGREE)
				out_degree_ready <= 1'b1;
			else
				edges_idx_ready <= 1'b1;
			if (half_0_count == '0) begin
				if (read_response.real_size > line_count_t'(`VJ_HALF_VERTICES)) begin
					half_0_count <= line_count_t'(`VJ_HALF_VERTICES);
					half_1_count <= read_response.real_size - line_count_t'(`VJ_HALF_VERTICES);
				end else begin
					half_0_count <= read_response.real_size;
					half_1_count <= '0;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// vertex output
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			shift_d     <= 1'b0;
			vertex_push <= 1'b0;
			id_count    <= '0;
		end else begin
			shift_d     <= shift_half_0 || shift_half_1;
			vertex_push <= shift_d;
			if (shift_d)
				id_count <= id_count + 1'b1;
		end
	end

	// top word of the selected half, then tag with the running id
	always_ff @(posedge clock) begin
		out_degree_word   <= out_degree_half[shift_sel][HALF_BITS-1 -: `VJ_VERTEX_BITS];
		edges_idx_word    <= edges_idx_half[shift_sel][HALF_BITS-1 -: `VJ_VERTEX_BITS];
		vertex_out.id         <= wed.first_id + id_count;
		vertex_out.out_degree <= out_degree_word;
		vertex_out.edges_idx  <= edges_idx_word;
	end

endmodule

`default_nettype wire

/* hdl/vertex_read_sequencer.sv */
//////////////////////////////////////////////////
// one chunk at a time, started only with an empty command
// queue and room for a full line in the vertex buffer
// the descriptor is loaded once after wed_valid rises
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vertex_job_settings.svh"

module vertex_read_sequencer
	import vertex_job_pkg::*;
(
	input  logic          clock,
	input  logic          rstn,
	input  logic          wed_valid,
	input  wed_t          wed,
	input  logic          command_queue_empty,
	input  logic          vertex_room,
	input  logic          line_ready,
	input  line_count_t   half_0_count,
	input  line_count_t   half_1_count,
	output logic          command_push,
	output read_command_t command,
	output logic          clear_line,
	output logic          shift_half_0,
	output logic          shift_half_1
);

	seq_state_t   state;
	seq_state_t   next_state;
	vertex_word_t remaining;
	line_count_t  chunk_size;
	byte_addr_t   offset;
	line_count_t  shift_count;
	logic         chunk_go;
	logic         shift_last;

	assign chunk_go = wed_valid && (remaining != '0) && command_queue_empty && vertex_room;

	// last strobe of the half being shifted
	assign shift_last = (state == SEQ_SHIFT_0) ? (shift_count + 1'b1 == half_0_count) :
		(shift_count + 1'b1 == half_1_count);

	assign shift_half_0 = (state == SEQ_SHIFT_0);
	assign shift_half_1 = (state == SEQ_SHIFT_1);
	assign clear_line   = (state == SEQ_CLEAR);

	//////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			state <= SEQ_WAIT_WED;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			SEQ_WAIT_WED: begin
				if (wed_valid)
					next_state = SEQ_LOAD;
			end
			SEQ_LOAD:       next_state = SEQ_IDLE;
			SEQ_IDLE: begin
				if (chunk_go)
					next_state = SEQ_START;
			end
			SEQ_START:      next_state = SEQ_SIZE;
			SEQ_SIZE:       next_state = SEQ_OUT_DEGREE;
			SEQ_OUT_DEGREE: next_state = SEQ_EDGES_IDX;
			SEQ_EDGES_IDX:  next_state = SEQ_WAIT_LINE;
			SEQ_WAIT_LINE: begin
				if (line_ready)
					next_state = SEQ_SHIFT_0;
			end
			SEQ_SHIFT_0: begin
				if (shift_last)
					next_state = (half_1_count != '0) ? SEQ_SHIFT_1 : SEQ_CLEAR;
			end
			SEQ_SHIFT_1: begin
				if (shift_last)
					next_state = SEQ_CLEAR;
			end
			SEQ_CLEAR:      next_state = SEQ_IDLE;
			default:        next_state = SEQ_WAIT_WED;
		endcase
	end

	//////////////////////////////////////////////////
	// chunk bookkeeping
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			remaining    <= '0;
			chunk_size   <= '0;
			offset       <= '0;
			shift_count  <= '0;
			command_push <= 1'b0;
		end else begin
			command_push <= (state == SEQ_OUT_DEGREE) || (state == SEQ_EDGES_IDX);
			case (state)
				SEQ_LOAD: begin
					remaining <= wed.num_vertices;
					offset    <= '0;
				end
				// a full line unless the tail is shorter
				SEQ_START: begin
					if (remaining > `VJ_LINE_VERTICES)
						chunk_size <= line_count_t'(`VJ_LINE_VERTICES);
					else
						chunk_size <= line_count_t'(remaining);
				end
				SEQ_SIZE:      remaining <= remaining - vertex_word_t'(chunk_size);
				SEQ_EDGES_IDX: offset <= offset + byte_addr_t'(`VJ_LINE_BYTES);
				default: begin
				end
			endcase
			if (shift_half_0 || shift_half_1)
				shift_count <= shift_last ? '0 : shift_count + 1'b1;
			else
				shift_count <= '0;
		end
	end

	// out-degree command first, edge-index next cycle
	always_ff @(posedge clock) begin
		if (state == SEQ_OUT_DEGREE) begin
			command.address   <= wed.out_degree_base + offset;
			command.array_sel <= OUT_DEGREE;
			command.real_size <= chunk_size;
		end else if (state == SEQ_EDGES_IDX) begin
			command.address   <= wed.edges_idx_base + offset;
			command.array_sel <= EDGES_IDX;
			command.real_size <= chunk_size;
		end
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hdl
hdl/vertex_job_pkg.sv
hdl/sync_fifo.sv
hdl/vertex_read_sequencer.sv
hdl/vertex_line_unpacker.sv
hdl/read_command_queue.sv
hdl/vertex_job_control.sv
testbench/vertex_job_control_tb.sv

/* testbench/vertex_job_control_tb.sv */
//////////////////////////////////////////////////
// each job runs after its own reset, since the DUT
// loads the descriptor only once per reset
// memory word at byte address a is a fixed hash of a
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vertex_job_settings.svh"

module vertex_job_control_tb
	import vertex_job_pkg::*;
;

	localparam int TOTAL_VERTICES  = 37 + 5 + 16 + 37;
	localparam int WATCHDOG_CYCLES = 200 * TOTAL_VERTICES + 1000;
	localparam int ROOM_LIMIT      = `VJ_VERTEX_FIFO_DEPTH - `VJ_LINE_VERTICES + 1;
	localparam logic [15:0] LFSR_TAPS = 16'hb400;

	logic           clock = 1'b0;
	logic           rstn = 1'b0;
	logic           wed_valid = 1'b0;
	wed_t           wed = '0;
	logic           read_command_grant = 1'b0;
	logic           read_buffer_alfull = 1'b0;
	logic           read_command_request;
	logic           read_command_valid;
	read_command_t  read_command;
	logic           read_response_valid = 1'b0;
	read_response_t read_response = '0;
	logic           read_data_0_valid = 1'b0;
	logic           read_data_1_valid = 1'b0;
	read_data_t     read_data_0 = '0;
	read_data_t     read_data_1 = '0;
	logic           vertex_request = 1'b0;
	logic           vertex_valid;
	vertex_t        vertex;

	logic [15:0]   lfsr = 16'd53;
	logic          request_sparse = 1'b0;
	logic          stall_enable = 1'b0;
	logic          alfull_prev = 1'b0;
	int            stall_left = 0;
	int            mem_phase = 0;
	int            mem_wait = 0;
	read_command_t mem_cmd;
	read_command_t pending [$];
	int            job_vertices = 0;
	int            job_chunks = 0;
	int            cmd_index = 0;
	int            vert_index = 0;

	vertex_job_control u_vertex_job_control (.*);

	always #4 clock = ~clock;

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	// one LFSR step per bit taken
	function automatic logic [7:0] take_bits(input int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			r = {r[6:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic vertex_word_t mem_word(input byte_addr_t a);
		return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5bd1_e995;
	endfunction

	// vertex 0 of a half in the top word
	function automatic half_line_t half_data(input byte_addr_t line_addr, input int half);
		half_line_t d;
		byte_addr_t a;
		d = '0;
		for (int i = 0; i < `VJ_HALF_VERTICES; i++) begin
			a = line_addr + byte_addr_t'(4 * (`VJ_HALF_VERTICES * half + i));
			d[$bits(half_line_t)-1-`VJ_VERTEX_BITS*i -: `VJ_VERTEX_BITS] = mem_word(a);
		end
		return d;
	endfunction

	function automatic vertex_t ref_vertex(input wed_t w, input int k);
		vertex_t v;
		v.id         = w.first_id + vertex_word_t'(k);
		v.out_degree = mem_word(w.out_degree_base + byte_addr_t'(4 * k));
		v.edges_idx  = mem_word(w.edges_idx_base + byte_addr_t'(4 * k));
		return v;
	endfunction

	task automatic report_failure();
		$display("sim failed");
		$fatal(1);
	endtask

	//////////////////////////////////////////////////
	// bus, stall, consumer and memory model
	//////////////////////////////////////////////////

	always @(posedge clock) begin
		read_data_0_valid   <= 1'b0;
		read_data_1_valid   <= 1'b0;
		read_response_valid <= 1'b0;
		if (!rstn) begin
			read_command_grant <= 1'b0;
			read_buffer_alfull <= 1'b0;
			vertex_request     <= 1'b0;
			pending.delete();
			mem_phase  = 0;
			stall_left = 0;
		end else begin
			read_command_grant <= read_command_request && !read_command_grant &&
				(take_bits(1) != 0);
			if (stall_left != 0)
				stall_left = stall_left - 1;
			else if (stall_enable && take_bits(4) == 0)
				stall_left = 12 + take_bits(4);
			read_buffer_alfull <= (stall_left != 0);
			if (request_sparse)
				vertex_request <= (take_bits(3) == 0);
			else
				vertex_request <= (take_bits(1) != 0);
			if (read_command_valid)
				pending.push_back(read_command);
			// one command at a time: wait, half 0, half 1, response
			case (mem_phase)
				0: begin
					if (pending.size() != 0) begin
						mem_cmd   = pending.pop_front();
						mem_wait  = 1 + take_bits(3);
						mem_phase = 1;
					end
				end
				1: begin
					mem_wait = mem_wait - 1;
					if (mem_wait == 0) begin
						read_data_0_valid     <= 1'b1;
						read_data_0.array_sel <= mem_cmd.array_sel;
						read_data_0.data      <= half_data(mem_cmd.address, 0);
						mem_phase = 2;
					end
				end
				2: begin
					read_data_1_valid     <= 1'b1;
					read_data_1.array_sel <= mem_cmd.array_sel;
					read_data_1.data      <= half_data(mem_cmd.address, 1);
					mem_phase = 3;
				end
				default: begin
					read_response_valid     <= 1'b1;
					read_response.array_sel <= mem_cmd.array_sel;
					read_response.real_size <= mem_cmd.real_size;
					mem_phase = 0;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// checker
	//////////////////////////////////////////////////

	task automatic check_command();
		int         chunk;
		int         size;
		byte_addr_t exp_addr;
		array_sel_t exp_sel;
		chunk = cmd_index / 2;
		assert (cmd_index < 2 * job_chunks) else begin
			$display("read command %0d issued beyond the end of the job", cmd_index);
			report_failure();
		end
		size = job_vertices - `VJ_LINE_VERTICES * chunk;
		if (size > `VJ_LINE_VERTICES)
			size = `VJ_LINE_VERTICES;
		exp_sel  = (cmd_index % 2 == 0) ? OUT_DEGREE : EDGES_IDX;
		exp_addr = (exp_sel == OUT_DEGREE) ? wed.out_degree_base : wed.edges_idx_base;
		exp_addr = exp_addr + byte_addr_t'(`VJ_LINE_BYTES * chunk);
		assert (read_command.array_sel == exp_sel) else begin
			$display("[ERROR] read_command.array_sel cmd %0d: got %h expected %h",
				cmd_index, read_command.array_sel, exp_sel);
			report_failure();
		end
		assert (read_command.address == exp_addr) else begin
			$display("[ERROR] read_command.address cmd %0d: got %h expected %h",
				cmd_index, read_command.address, exp_addr);
			report_failure();
		end
		assert (read_command.real_size == line_count_t'(size)) else begin
			$display("[ERROR] read_command.real_size cmd %0d: got %h expected %h",
				cmd_index, read_command.real_size, size);
			report_failure();
		end
		// one vertex may still be in flight when the chunk starts
		if (exp_sel == OUT_DEGREE) begin
			assert (`VJ_LINE_VERTICES * chunk - vert_index <= ROOM_LIMIT) else begin
				$display("chunk %0d started while the vertex buffer lacked room", chunk);
				report_failure();
			end
		end
	endtask

	task automatic check_vertex();
		vertex_t exp;
		assert (vert_index < job_vertices) else begin
			$display("vertex %0d delivered beyond the end of the job", vert_index);
			report_failure();
		end
		exp = ref_vertex(wed, vert_index);
		assert (vertex.id == exp.id) else begin
			$display("[ERROR] vertex.id index %0d: got %h expected %h",
				vert_index, vertex.id, exp.id);
			report_failure();
		end
		assert (vertex.out_degree == exp.out_degree) else begin
			$display("[ERROR] vertex.out_degree index %0d: got %h expected %h",
				vert_index, vertex.out_degree, exp.out_degree);
			report_failure();
		end
		assert (vertex.edges_idx == exp.edges_idx) else begin
			$display("[ERROR] vertex.edges_idx index %0d: got %h expected %h",
				vert_index, vertex.edges_idx, exp.edges_idx);
			report_failure();
		end
	endtask

	always @(negedge clock) begin
		if (!rstn) begin
			cmd_index   = 0;
			vert_index  = 0;
			alfull_prev = 1'b0;
		end else begin
			if (!wed_valid) begin
				assert (!read_command_request && !read_command_valid && !vertex_valid)
				else begin
					$display("DUT outputs active before the descriptor was valid");
					report_failure();
				end
			end
			// request and pop both see alfull one cycle late
			assert (!(alfull_prev && (read_command_valid || read_command_request))) else begin
				$display("bus request or read command while the read buffer was almost full");
				report_failure();
			end
			if (read_command_valid) begin
				check_command();
				cmd_index++;
			end
			if (vertex_valid) begin
				check_vertex();
				vert_index++;
			end
			alfull_prev = read_buffer_alfull;
		end
	end

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	task automatic run_job(input int n, input vertex_word_t first_id, input byte_addr_t od_base,
		input byte_addr_t ei_base, input logic sparse, input logic stall);
		@(posedge clock);
		rstn      <= 1'b0;
		wed_valid <= 1'b0;
		wed.num_vertices    <= vertex_word_t'(n);
		wed.first_id        <= first_id;
		wed.out_degree_base <= od_base;
		wed.edges_idx_base  <= ei_base;
		repeat (8) @(posedge clock);
		request_sparse = sparse;
		stall_enable   = stall;
		job_vertices   = n;
		job_chunks     = (n + `VJ_LINE_VERTICES - 1) / `VJ_LINE_VERTICES;
		rstn <= 1'b1;
		// outputs must stay quiet until the descriptor is valid
		repeat (10) @(posedge clock);
		wed_valid <= 1'b1;
		if (n == 0) begin
			repeat (200) @(posedge clock);
			assert (cmd_index == 0 && vert_index == 0) else begin
				$display("empty job produced commands or vertices");
				report_failure();
			end
		end else begin
			while (vert_index < n || cmd_index < 2 * job_chunks)
				@(posedge clock);
			// late duplicates would show up here
			repeat (20) @(posedge clock);
		end
	endtask

	initial begin
		run_job(37, 32'h0000_1000, 32'h0010_0000, 32'h0020_0100, 1'b0, 1'b0);
		run_job(5, 32'h0000_2345, 32'h0031_0040, 32'h0042_0080, 1'b0, 1'b0);
		run_job(16, 32'h00ab_0000, 32'h0050_0000, 32'h0060_0000, 1'b0, 1'b0);
		run_job(37, 32'h0000_0077, 32'h0070_0200, 32'h0080_0300, 1'b1, 1'b1);
		run_job(0, 32'h0000_0001, 32'h0090_0000, 32'h00a0_0000, 1'b0, 1'b0);
		$display("sim passed");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("timeout after %0d cycles without finishing the jobs", WATCHDOG_CYCLES);
		report_failure();
	end

endmodule

`default_nettype wire
